//--- all.f
+incdir+.
i3c_rx_pkg.sv
target_rx_fsm.sv
descriptor_rx.sv
rx_queue.sv
i3c_rx_top.sv
tb_i3c_rx.sv

//--- descriptor_rx.sv
// RX descriptor generator
`timescale 1ns/1ns
`default_nettype none

module descriptor_rx
  import i3c_rx_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // From the bit receiver
  input  logic [7:0]             rx_byte_i,
  input  logic                   rx_byte_valid_i,
  input  logic                   rx_byte_last_i,
  input  logic                   rx_byte_err_i,
  input  rx_err_e                rx_byte_err_code_i,
  output logic                   rx_byte_ready_o,

  // RX data queue write side
  input  logic                   tti_rx_queue_full_i,
  output logic                   tti_rx_queue_wvalid_o,
  output logic [RxDataWidth-1:0] tti_rx_queue_wdata_o,

  // RX descriptor queue write side
  output logic                   tti_rx_desc_queue_wvalid_o,
  output rx_desc_t               tti_rx_desc_queue_wdata_o
);

  logic [RxLenWidth-1:0] byte_cnt_q;
  logic [RxLenWidth-1:0] len_q;
  rx_err_e               err_q;
  logic                  transfer_end;
  logic                  byte_accept;
  logic                  transfer_end_q;

  // Either end pulse closes the transfer
  assign transfer_end = rx_byte_last_i | rx_byte_err_i;
  assign byte_accept  = rx_byte_valid_i & rx_byte_ready_o;

  // Room in the data queue
  assign rx_byte_ready_o = ~tti_rx_queue_full_i;

  // Byte goes straight into the data queue
  assign tti_rx_queue_wvalid_o = byte_accept;
  assign tti_rx_queue_wdata_o  = rx_byte_i;

  // Bytes accepted in the current transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_count
    if (!rst_ni) begin
      byte_cnt_q <= '0;
    end else if (transfer_end) begin
      byte_cnt_q <= '0;
    end else if (byte_accept) begin
      byte_cnt_q <= byte_cnt_q + 1'b1;
    end
  end

  // Capture length and error code at the end pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_capture
    if (!rst_ni) begin
      len_q          <= '0;
      err_q          <= RX_ERR_NONE;
      transfer_end_q <= 1'b0;
    end else begin
      transfer_end_q <= transfer_end;
      if (transfer_end) begin
        len_q <= byte_cnt_q;
        err_q <= rx_byte_err_i ? rx_byte_err_code_i : RX_ERR_NONE;
      end
    end
  end

  // Descriptor pushed one cycle after the end pulse
  assign tti_rx_desc_queue_wvalid_o     = transfer_end_q;
  assign tti_rx_desc_queue_wdata_o.err  = err_q;
  assign tti_rx_desc_queue_wdata_o.rsvd = '0;
  assign tti_rx_desc_queue_wdata_o.len  = len_q;

  // Length field cannot wrap inside one transfer
  a_no_wrap : assert property (@(posedge clk_i) disable iff (!rst_ni)
    byte_accept |-> (byte_cnt_q != '1));

endmodule

`default_nettype wire

//--- i3c_rx_pkg.sv
// I3C RX path definitions
`default_nettype none

package i3c_rx_pkg;

  // Width of one entry in the RX data queue
  localparam int unsigned RxDataWidth = 8;

  // Width of one entry in the RX descriptor queue
  localparam int unsigned RxDescWidth = 32;

  // Number of entries in the RX data queue
  localparam int unsigned RxDataDepth = 8;

  // Number of entries in the RX descriptor queue
  localparam int unsigned RxDescDepth = 4;

  // Width of the per-transfer byte counter
  localparam int unsigned RxLenWidth = 16;

  // Error code reported in the descriptor
  typedef enum logic [3:0] {
    RX_ERR_NONE     = 4'd0,
    // T-bit did not give odd parity
    RX_ERR_PARITY   = 4'd1,
    // Byte arrived with the data queue full
    RX_ERR_OVERFLOW = 4'd2
  } rx_err_e;

  // RX descriptor, most significant field first
  typedef struct packed {
    rx_err_e               err;
    logic [11:0]           rsvd;
    logic [RxLenWidth-1:0] len;
  } rx_desc_t;

  // Bit receiver states
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_DATA,
    RX_TBIT,
    RX_DISCARD
  } rx_state_e;

endpackage

`default_nettype wire

//--- i3c_rx_top.sv
// I3C target RX path top
`timescale 1ns/1ns
`default_nettype none

module i3c_rx_top
  import i3c_rx_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Sampled bus bits
  input  logic                   bit_valid_i,
  input  logic                   bit_i,
  input  logic                   stop_i,

  // Data queue read side
  input  logic                   data_pop_i,
  output logic [RxDataWidth-1:0] data_o,
  output logic                   data_empty_o,

  // Descriptor queue read side
  input  logic                   desc_pop_i,
  output rx_desc_t               desc_o,
  output logic                   desc_empty_o
);

  // Receiver to descriptor block
  logic [7:0]             rx_byte;
  logic                   rx_byte_valid;
  logic                   rx_byte_last;
  logic                   rx_byte_err;
  rx_err_e                rx_byte_err_code;
  logic                   rx_byte_ready;

  // Descriptor block to queues
  logic                   data_push;
  logic [RxDataWidth-1:0] data_wdata;
  logic                   data_full;
  logic                   desc_push;
  rx_desc_t               desc_wdata;

  target_rx_fsm u_rx_fsm (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .bit_valid_i        (bit_valid_i),
    .bit_i              (bit_i),
    .stop_i             (stop_i),
    .rx_byte_ready_i    (rx_byte_ready),
    .rx_byte_o          (rx_byte),
    .rx_byte_valid_o    (rx_byte_valid),
    .rx_byte_last_o     (rx_byte_last),
    .rx_byte_err_o      (rx_byte_err),
    .rx_byte_err_code_o (rx_byte_err_code)
  );

  descriptor_rx u_desc_rx (
    .clk_i                      (clk_i),
    .rst_ni                     (rst_ni),
    .rx_byte_i                  (rx_byte),
    .rx_byte_valid_i            (rx_byte_valid),
    .rx_byte_last_i             (rx_byte_last),
    .rx_byte_err_i              (rx_byte_err),
    .rx_byte_err_code_i         (rx_byte_err_code),
    .rx_byte_ready_o            (rx_byte_ready),
    .tti_rx_queue_full_i        (data_full),
    .tti_rx_queue_wvalid_o      (data_push),
    .tti_rx_queue_wdata_o       (data_wdata),
    .tti_rx_desc_queue_wvalid_o (desc_push),
    .tti_rx_desc_queue_wdata_o  (desc_wdata)
  );

  // RX data bytes
  rx_queue #(.Width(RxDataWidth), .Depth(RxDataDepth)) u_data_q (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (data_push),
    .wdata_i (data_wdata),
    .pop_i   (data_pop_i),
    .rdata_o (data_o),
    .full_o  (data_full),
    .empty_o (data_empty_o)
  );

  // RX descriptors, a push while full is dropped by the queue
  rx_queue #(.Width(RxDescWidth), .Depth(RxDescDepth)) u_desc_q (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (desc_push),
    .wdata_i (desc_wdata),
    .pop_i   (desc_pop_i),
    .rdata_o (desc_o),
    .full_o  (),
    .empty_o (desc_empty_o)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the I3C RX testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_i3c_rx -f all.f

out="$(./obj_dir/Vtb_i3c_rx)"
echo "$out"

if echo "$out" | grep -q "^Done: no errors$"; then
  exit 0
fi
exit 1

//--- rx_queue.sv
// Show-ahead FIFO
`timescale 1ns/1ns
`default_nettype none

module rx_queue #(
  parameter int unsigned Width = 8,
  // Power of two, pointers wrap on overflow
  parameter int unsigned Depth = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,

  // Write side
  input  logic             push_i,
  input  logic [Width-1:0] wdata_i,

  // Read side, head entry always on rdata_o
  input  logic             pop_i,
  output logic [Width-1:0] rdata_o,
  output logic             full_o,
  output logic             empty_o
);

  logic [Width-1:0]             mem_q [Depth];
  logic [$clog2(Depth)-1:0]     wr_ptr_q;
  logic [$clog2(Depth)-1:0]     rd_ptr_q;
  logic [$clog2(Depth+1)-1:0]   count_q;
  logic                         push_ok;
  logic                         pop_ok;

  assign full_o  = (count_q == ($clog2(Depth+1))'(Depth));
  assign empty_o = (count_q == '0);

  // Push into a full queue is dropped
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;

  // Storage
  always_ff @(posedge clk_i) begin : proc_mem
    if (push_ok) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ptr
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Head entry shown directly
  assign rdata_o = mem_q[rd_ptr_q];

  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- target_rx_fsm.sv
// I3C target bit receiver
`timescale 1ns/1ns
`default_nettype none

module target_rx_fsm
  import i3c_rx_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // Sampled bus bits and end of transfer
  input  logic       bit_valid_i,
  input  logic       bit_i,
  input  logic       stop_i,

  // Towards the descriptor block
  input  logic       rx_byte_ready_i,
  output logic [7:0] rx_byte_o,
  output logic       rx_byte_valid_o,
  output logic       rx_byte_last_o,
  output logic       rx_byte_err_o,
  output rx_err_e    rx_byte_err_code_o
);

  rx_state_e  state_q;
  logic [7:0] shift_q;
  logic [2:0] bit_cnt_q;
  logic       data_bit;
  logic       tbit;
  logic       parity_ok;

  // Strobe of a data bit, stop wins over a bit in the same cycle
  assign data_bit = bit_valid_i & ~stop_i &
                    ((state_q == RX_IDLE) | (state_q == RX_DATA));

  // Strobe of the ninth bit of a byte
  assign tbit = bit_valid_i & ~stop_i & (state_q == RX_TBIT);

  // Data ones plus T-bit must be odd
  assign parity_ok = ^{shift_q, bit_i};

  // Shift register, MSB arrives first
  always_ff @(posedge clk_i) begin : proc_shift
    if (data_bit) begin
      shift_q <= {shift_q[6:0], bit_i};
    end
  end

  // Byte handed over on the cycle after the T-bit
  always_ff @(posedge clk_i) begin : proc_byte
    if (tbit) begin
      rx_byte_o <= shift_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_fsm
    if (!rst_ni) begin
      state_q            <= RX_IDLE;
      bit_cnt_q          <= '0;
      rx_byte_valid_o    <= 1'b0;
      rx_byte_last_o     <= 1'b0;
      rx_byte_err_o      <= 1'b0;
      rx_byte_err_code_o <= RX_ERR_NONE;
    end else begin
      // Pulses last one cycle
      rx_byte_valid_o <= 1'b0;
      rx_byte_last_o  <= 1'b0;
      rx_byte_err_o   <= 1'b0;

      if (stop_i) begin
        // Partial byte is thrown away
        bit_cnt_q <= '0;
        state_q   <= RX_IDLE;
        // An error pulse already closed this transfer
        if (state_q != RX_DISCARD) begin
          rx_byte_last_o <= 1'b1;
        end
      end else if (bit_valid_i) begin
        unique case (state_q)
          RX_IDLE, RX_DATA: begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= RX_TBIT;
            end else begin
              state_q <= RX_DATA;
            end
          end
          RX_TBIT: begin
            bit_cnt_q <= '0;
            if (!parity_ok) begin
              rx_byte_err_o      <= 1'b1;
              rx_byte_err_code_o <= RX_ERR_PARITY;
              state_q            <= RX_DISCARD;
            end else if (!rx_byte_ready_i) begin
              // No room, byte is lost
              rx_byte_err_o      <= 1'b1;
              rx_byte_err_code_o <= RX_ERR_OVERFLOW;
              state_q            <= RX_DISCARD;
            end else begin
              rx_byte_valid_o <= 1'b1;
              state_q         <= RX_IDLE;
            end
          end
          default: begin
            // Ignore bits until the next stop
            state_q <= RX_DISCARD;
          end
        endcase
      end
    end
  end

  // Byte, end and error never meet in one cycle
  a_pulse_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({rx_byte_valid_o, rx_byte_last_o, rx_byte_err_o}));

  // Data queue still has room when the byte arrives there
  a_valid_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_byte_valid_o |-> rx_byte_ready_i);

endmodule

`default_nettype wire

//--- tb_i3c_rx_tasks.svh
// I3C RX stimulus tasks
`ifndef TB_I3C_RX_TASKS_SVH
`define TB_I3C_RX_TASKS_SVH

// One bus bit, strobe stays high until the next driver call
task automatic send_bit(input logic b);
  @(posedge clk_i);
  bit_valid_i <= 1'b1;
  bit_i       <= b;
endtask

// Eight data bits MSB first, then the T-bit
task automatic send_byte(input logic [7:0] data, input logic tbit);
  for (int i = 7; i >= 0; i--) begin
    send_bit(data[i]);
  end
  send_bit(tbit);
endtask

// STOP strobe, bit strobes end here
task automatic send_stop();
  @(posedge clk_i);
  bit_valid_i <= 1'b0;
  stop_i      <= 1'b1;
  @(posedge clk_i);
  stop_i      <= 1'b0;
endtask

// Random bytes, byte bad_idx gets a wrong T-bit, then a STOP
task automatic send_transfer(input int n_bytes, input int bad_idx);
  logic [7:0] data;
  logic       tbit;
  rx_err_e    err;
  int         len;
  rx_desc_t   desc;
  err = RX_ERR_NONE;
  len = 0;
  for (int i = 0; i < n_bytes; i++) begin
    data = 8'($random(seed));
    // Ones in data plus T-bit come out odd
    tbit = ~(^data);
    if (i == bad_idx) begin
      tbit = ~tbit;
    end
    send_byte(data, tbit);
    // First error closes the transfer, later bytes are lost
    if (err == RX_ERR_NONE) begin
      if (i == bad_idx) begin
        err = RX_ERR_PARITY;
      end else if (exp_data_q.size() >= int'(RxDataDepth)) begin
        err = RX_ERR_OVERFLOW;
      end else begin
        exp_data_q.push_back(data);
        len++;
      end
    end
  end
  send_stop();
  desc.err  = err;
  desc.rsvd = '0;
  desc.len  = RxLenWidth'(len);
  exp_desc_q.push_back(desc);
endtask

// Wait for a byte at the head and pop it, expected head goes along
task automatic pop_data();
  int waited;
  waited = 0;
  @(negedge clk_i);
  while (data_empty_o && waited < PopWait) begin
    @(negedge clk_i);
    waited++;
  end
  if (data_empty_o) begin
    errors++;
    $display("ERROR at %0t: data queue stayed empty while a byte was expected", $time);
    exp_data_q.delete(0);
  end else if (exp_data_q.size() == 0) begin
    errors++;
    $display("ERROR at %0t: data queue holds a byte that no transfer sent", $time);
  end else begin
    @(posedge clk_i);
    data_pop_i    <= 1'b1;
    exp_data_head <= exp_data_q.pop_front();
    @(posedge clk_i);
    data_pop_i    <= 1'b0;
  end
endtask

// Same for the descriptor queue
task automatic pop_desc();
  int waited;
  waited = 0;
  @(negedge clk_i);
  while (desc_empty_o && waited < PopWait) begin
    @(negedge clk_i);
    waited++;
  end
  if (desc_empty_o) begin
    errors++;
    $display("ERROR at %0t: descriptor queue stayed empty after a transfer", $time);
    exp_desc_q.delete(0);
  end else begin
    @(posedge clk_i);
    desc_pop_i    <= 1'b1;
    exp_desc_head <= exp_desc_q.pop_front();
    @(posedge clk_i);
    desc_pop_i    <= 1'b0;
  end
endtask

`endif

//--- tb_i3c_rx.sv
// I3C RX path testbench
`timescale 1ns/1ns
`default_nettype none

module tb_i3c_rx
  import i3c_rx_pkg::*;
();

  // Bytes per test, reset check has none
  localparam int TestBytes = 5 + 4 + 10 + 5 + 12;
  localparam int NumTests  = 6;
  localparam int MaxCycles = 2 * (TestBytes * 12 + NumTests * 20);
  localparam int PopWait   = 64;
  localparam int Settle    = 4;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   bit_valid_i;
  logic                   bit_i;
  logic                   stop_i;
  logic                   data_pop_i;
  logic                   desc_pop_i;
  logic [RxDataWidth-1:0] data_o;
  logic                   data_empty_o;
  rx_desc_t               desc_o;
  logic                   desc_empty_o;

  // Scoreboard
  logic [RxDataWidth-1:0] exp_data_q [$];
  rx_desc_t               exp_desc_q [$];
  logic [RxDataWidth-1:0] exp_data_head;
  rx_desc_t               exp_desc_head;
  logic                   check_empty;

  integer seed;
  int     errors;
  int     errors_at_start;
  int     tests_run;
  int     tests_failed;
  int     cycle_cnt;

  i3c_rx_top dut0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bit_valid_i  (bit_valid_i),
    .bit_i        (bit_i),
    .stop_i       (stop_i),
    .data_pop_i   (data_pop_i),
    .data_o       (data_o),
    .data_empty_o (data_empty_o),
    .desc_pop_i   (desc_pop_i),
    .desc_o       (desc_o),
    .desc_empty_o (desc_empty_o)
  );

  `include "tb_i3c_rx_tasks.svh"

  initial begin
    clk_i = 1'b0;
  end

  // 20 ns period
  always #10 clk_i = ~clk_i;

  // Popped head must match the oldest expected entry
  a_data_head : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_pop_i |-> (data_o == exp_data_head))
    else begin
      errors++;
      $display("MISMATCH at %0t: data_o expected %h got %h",
               $time, $sampled(exp_data_head), $sampled(data_o));
    end

  a_desc_head : assert property (@(posedge clk_i) disable iff (!rst_ni)
    desc_pop_i |-> (desc_o == exp_desc_head))
    else begin
      errors++;
      $display("MISMATCH at %0t: desc_o expected %h got %h",
               $time, $sampled(exp_desc_head), $sampled(desc_o));
    end

  // Queues drained by the scoreboard read back as empty
  a_data_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_empty |-> data_empty_o)
    else begin
      errors++;
      $display("MISMATCH at %0t: data_empty_o expected 1 got %b",
               $time, $sampled(data_empty_o));
    end

  a_desc_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_empty |-> desc_empty_o)
    else begin
      errors++;
      $display("MISMATCH at %0t: desc_empty_o expected 1 got %b",
               $time, $sampled(desc_empty_o));
    end

  // Pop all expected entries, then both queues must be empty
  task automatic drain_queues();
    while (exp_data_q.size() > 0) begin
      pop_data();
    end
    while (exp_desc_q.size() > 0) begin
      pop_desc();
    end
    repeat (Settle) @(posedge clk_i);
    check_empty <= 1'b1;
    @(posedge clk_i);
    check_empty <= 1'b0;
  endtask

  // Let assertion actions land, then report this test
  task automatic finish_test(input string name);
    int test_errors;
    repeat (2) @(posedge clk_i);
    test_errors = errors - errors_at_start;
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("Test %-16s %s (%0d errors)", name,
             (test_errors == 0) ? "ok" : "FAILED", test_errors);
    errors_at_start = errors;
  endtask

  always @(posedge clk_i) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("TIMEOUT: run did not finish within %0d cycles", MaxCycles);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin : main
    seed            = 32'h9880;
    errors          = 0;
    errors_at_start = 0;
    tests_run       = 0;
    tests_failed    = 0;
    cycle_cnt       = 0;
    rst_ni          = 1'b0;
    bit_valid_i     = 1'b0;
    bit_i           = 1'b0;
    stop_i          = 1'b0;
    data_pop_i      = 1'b0;
    desc_pop_i      = 1'b0;
    check_empty     = 1'b0;
    exp_data_head   = '0;
    exp_desc_head   = '0;

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Nothing queued before the first bit
    drain_queues();
    finish_test("reset_empty");

    send_transfer(5, -1);
    drain_queues();
    finish_test("clean_transfer");

    // Third byte bad, fourth byte ignored
    send_transfer(4, 2);
    drain_queues();
    finish_test("parity_error");

    // No pops, only the queue depth survives
    send_transfer(10, -1);
    drain_queues();
    finish_test("overflow");

    // Middle transfer is a STOP alone
    send_transfer(3, -1);
    send_transfer(0, -1);
    send_transfer(2, -1);
    drain_queues();
    finish_test("back_to_back");

    // Reads run while the bytes still arrive
    fork
      send_transfer(12, -1);
      begin
        repeat (12) pop_data();
      end
    join
    drain_queues();
    finish_test("pop_during_push");

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
